/* logic/cpuPkg.sv */
package cpuPkg;

	localparam int dataWidth = 32;
	localparam int regAddrWidth = 5;
	localparam int romAddrWidth = 8;  // 256 instruction words
	localparam int ramAddrWidth = 8;  // 256 data words
	localparam int shiftAmount = 1;

	// Instruction fields
	localparam int opcodeMsb = 31;
	localparam int opcodeLsb = 27;
	localparam int rdMsb = 26;
	localparam int rdLsb = 22;
	localparam int rs1Msb = 21;
	localparam int rs1Lsb = 17;
	localparam int rs2Msb = 16;
	localparam int rs2Lsb = 12;
	localparam int imm17Width = 17;  // Sign extended
	localparam int imm27Width = 27;  // Jump target, zero extended

	localparam romFile = "program.hex";

	// Gaps are the removed DIV, JR, JAL and IN codes
	typedef enum logic [4:0] {
		opAdd = 5'd0, opAddi = 5'd1, opSub = 5'd2, opSubi = 5'd3,
		opMul = 5'd4, opAnd = 5'd6, opXor = 5'd7, opOr = 5'd8,
		opNot = 5'd9, opSlt = 5'd10, opSlet = 5'd11, opSgt = 5'd12,
		opSget = 5'd13, opSet = 5'd14, opSr = 5'd15, opSl = 5'd16,
		opJ = 5'd18, opBeq = 5'd20, opBneq = 5'd21, opLoad = 5'd22,
		opStore = 5'd23, opOut = 5'd25, opNop = 5'd26, opHlt = 5'd27
	} opcodeT;

	typedef enum logic [3:0] {
		aluAdd, aluSub, aluMul, aluAnd,
		aluXor, aluOr, aluNot, aluShr,
		aluShl, aluLt, aluLe, aluGt,
		aluGe, aluEq, aluNe, aluPassB
	} aluOpT;

endpackage

/* logic/fetchUnit.sv */
`timescale 1ns/1ps

module fetchUnit
	import cpuPkg::*;
(
	input logic clk,
	input logic rstN,
	input logic redirect,
	input logic [dataWidth-1:0] redirectPc,
	input logic isHalt,
	output logic [dataWidth-1:0] instr,
	output logic [dataWidth-1:0] pcPlusOne,
	output logic halted
);

	logic [dataWidth-1:0] pc;
	logic [dataWidth-1:0] rom [0:2**romAddrWidth-1];

	initial
	begin
		$readmemh(romFile, rom);
	end

	assign instr = rom[pc[romAddrWidth-1:0]];  // Combinational ROM read
	assign pcPlusOne = pc + 1'b1;

	always_ff @(posedge clk)
	begin
		if (!rstN)
		begin
			pc <= '0;
			halted <= 1'b0;
		end
		else if (isHalt)
			halted <= 1'b1;  // PC holds, flag sticks until reset
		else if (redirect)
			pc <= redirectPc;
		else
			pc <= pcPlusOne;
	end

endmodule

/* logic/decodeUnit.sv */
`timescale 1ns/1ps

module decodeUnit
	import cpuPkg::*;
(
	input logic [dataWidth-1:0] instr,
	output aluOpT aluOp,
	output logic useImm,
	output logic regWrite,
	output logic memWrite,
	output logic memToReg,
	output logic isBranch,
	output logic isJump,
	output logic isOut,
	output logic isHalt,
	output logic [regAddrWidth-1:0] rs1,
	output logic [regAddrWidth-1:0] rs2,
	output logic [regAddrWidth-1:0] rd,
	output logic [dataWidth-1:0] immShort,
	output logic [dataWidth-1:0] jumpTarget
);

	opcodeT op;

	assign op = opcodeT'(instr[opcodeMsb:opcodeLsb]);
	assign rd = instr[rdMsb:rdLsb];
	assign rs1 = instr[rs1Msb:rs1Lsb];
	assign rs2 = instr[rs2Msb:rs2Lsb];

	assign immShort = {{(dataWidth-imm17Width){instr[imm17Width-1]}}, instr[imm17Width-1:0]};
	assign jumpTarget = {{(dataWidth-imm27Width){1'b0}}, instr[imm27Width-1:0]};

	always_comb
	begin
		// NOP controls unless the opcode says otherwise
		aluOp = aluAdd;
		useImm = 1'b0;
		regWrite = 1'b0;
		memWrite = 1'b0;
		memToReg = 1'b0;
		isBranch = 1'b0;
		isJump = 1'b0;
		isOut = 1'b0;
		isHalt = 1'b0;
		case (op)
			opAdd: begin aluOp = aluAdd; regWrite = 1'b1; end
			opAddi: begin aluOp = aluAdd; useImm = 1'b1; regWrite = 1'b1; end
			opSub: begin aluOp = aluSub; regWrite = 1'b1; end
			opSubi: begin aluOp = aluSub; useImm = 1'b1; regWrite = 1'b1; end
			opMul: begin aluOp = aluMul; regWrite = 1'b1; end
			opAnd: begin aluOp = aluAnd; regWrite = 1'b1; end
			opXor: begin aluOp = aluXor; regWrite = 1'b1; end
			opOr: begin aluOp = aluOr; regWrite = 1'b1; end
			opNot: begin aluOp = aluNot; regWrite = 1'b1; end
			opSlt: begin aluOp = aluLt; regWrite = 1'b1; end
			opSlet: begin aluOp = aluLe; regWrite = 1'b1; end
			opSgt: begin aluOp = aluGt; regWrite = 1'b1; end
			opSget: begin aluOp = aluGe; regWrite = 1'b1; end
			opSet: begin aluOp = aluEq; regWrite = 1'b1; end
			opSr: begin aluOp = aluShr; regWrite = 1'b1; end
			opSl: begin aluOp = aluShl; regWrite = 1'b1; end
			opJ: isJump = 1'b1;
			opBeq: begin aluOp = aluEq; isBranch = 1'b1; end
			opBneq: begin aluOp = aluNe; isBranch = 1'b1; end
			opLoad: begin useImm = 1'b1; regWrite = 1'b1; memToReg = 1'b1; end  // rs1 + imm
			opStore: begin useImm = 1'b1; memWrite = 1'b1; end
			opOut: begin aluOp = aluPassB; isOut = 1'b1; end
			opHlt: isHalt = 1'b1;
			default: ;  // NOP and undefined codes
		endcase
	end

endmodule

/* logic/regFile.sv */
`timescale 1ns/1ps

module regFile
	import cpuPkg::*;
(
	input logic clk,
	input logic rstN,
	input logic [regAddrWidth-1:0] rs1,
	input logic [regAddrWidth-1:0] rs2,
	input logic [regAddrWidth-1:0] rd,
	input logic wbEnable,
	input logic [dataWidth-1:0] wbData,
	output logic [dataWidth-1:0] rs1Data,
	output logic [dataWidth-1:0] rs2Data,
	output logic [dataWidth-1:0] rdData
);

	logic [dataWidth-1:0] regs [0:2**regAddrWidth-1];

	// Asynchronous reads, rd port feeds STORE, OUT and branches
	assign rs1Data = regs[rs1];
	assign rs2Data = regs[rs2];
	assign rdData = regs[rd];

	always_ff @(posedge clk)
	begin
		if (!rstN)
		begin
			for (int i = 0; i < 2**regAddrWidth; i++)
				regs[i] <= '0;
		end
		else if (wbEnable)
			regs[rd] <= wbData;
	end

endmodule

/* logic/executeUnit.sv */
`timescale 1ns/1ps

module executeUnit
	import cpuPkg::*;
(
	input aluOpT aluOp,
	input logic useImm,
	input logic isBranch,
	input logic isJump,
	input logic [dataWidth-1:0] rs1Data,
	input logic [dataWidth-1:0] rs2Data,
	input logic [dataWidth-1:0] rdData,
	input logic [dataWidth-1:0] immShort,
	input logic [dataWidth-1:0] jumpTarget,
	output logic [dataWidth-1:0] aluResult,
	output logic redirect,
	output logic [dataWidth-1:0] redirectPc
);

	logic [dataWidth-1:0] opB;
	logic [dataWidth-1:0] cmpB;

	assign opB = useImm ? immShort : rs2Data;

	// Branches test rs1 against the rd register, SET tests rs1 against B
	assign cmpB = isBranch ? rdData : opB;

	always_comb
	begin
		case (aluOp)
			aluAdd: aluResult = rs1Data + opB;
			aluSub: aluResult = rs1Data - opB;
			aluMul: aluResult = rs1Data * opB;  // Low word of product
			aluAnd: aluResult = rs1Data & opB;
			aluXor: aluResult = rs1Data ^ opB;
			aluOr: aluResult = rs1Data | opB;
			aluNot: aluResult = ~rs1Data;
			aluShr: aluResult = rs1Data >> shiftAmount;
			aluShl: aluResult = rs1Data << shiftAmount;
			aluLt: aluResult = dataWidth'($signed(rs1Data) < $signed(opB));
			aluLe: aluResult = dataWidth'($signed(rs1Data) <= $signed(opB));
			aluGt: aluResult = dataWidth'($signed(rs1Data) > $signed(opB));
			aluGe: aluResult = dataWidth'($signed(rs1Data) >= $signed(opB));
			aluEq: aluResult = dataWidth'(rs1Data == cmpB);
			aluNe: aluResult = dataWidth'(rs1Data != cmpB);
			aluPassB: aluResult = opB;
			default: aluResult = '0;
		endcase
	end

	// Taken branch when the comparison gives 1
	assign redirect = isJump | (isBranch & aluResult[0]);

	// Absolute targets
	assign redirectPc = isJump ? jumpTarget : immShort;

endmodule

/* logic/resultUnit.sv */
`timescale 1ns/1ps

module resultUnit
	import cpuPkg::*;
(
	input logic clk,
	input logic rstN,
	input logic [dataWidth-1:0] aluResult,
	input logic [dataWidth-1:0] rdData,
	input logic regWrite,
	input logic memWrite,
	input logic memToReg,
	input logic isOut,
	output logic [dataWidth-1:0] wbData,
	output logic wbEnable,
	output logic [dataWidth-1:0] outData,
	output logic outStrobe
);

	logic [dataWidth-1:0] ram [0:2**ramAddrWidth-1];
	logic [ramAddrWidth-1:0] ramAddr;

	assign ramAddr = aluResult[ramAddrWidth-1:0];  // Address wraps at 256 words

	always_ff @(posedge clk)
	begin
		if (!rstN)
		begin
			for (int i = 0; i < 2**ramAddrWidth; i++)
				ram[i] <= '0;
		end
		else if (memWrite)
			ram[ramAddr] <= rdData;
	end

	// LOAD takes the RAM word, everything else the ALU
	assign wbData = memToReg ? ram[ramAddr] : aluResult;
	assign wbEnable = regWrite;

	always_ff @(posedge clk)
	begin
		if (!rstN)
			outStrobe <= 1'b0;
		else
			outStrobe <= isOut;  // One pulse per OUT
		if (isOut)
			outData <= rdData;
	end

endmodule

/* logic/cpuTop.sv */
`timescale 1ns/1ps

module cpuTop
	import cpuPkg::*;
(
	input logic clk,
	input logic rstN,
	output logic [dataWidth-1:0] outData,
	output logic outStrobe,
	output logic halted
);

	logic [dataWidth-1:0] instr;
	aluOpT aluOp;
	logic useImm, regWrite, memWrite, memToReg;
	logic isBranch, isJump, isOut, isHalt;
	logic [regAddrWidth-1:0] rs1, rs2, rd;
	logic [dataWidth-1:0] immShort, jumpTarget;
	logic [dataWidth-1:0] rs1Data, rs2Data, rdData;
	logic [dataWidth-1:0] aluResult, redirectPc, wbData;
	logic redirect, wbEnable;

	fetchUnit fetch (
		.clk(clk), .rstN(rstN), .redirect(redirect), .redirectPc(redirectPc),
		.isHalt(isHalt), .instr(instr), .pcPlusOne(), .halted(halted)
	);

	decodeUnit decode (
		.instr(instr), .aluOp(aluOp), .useImm(useImm), .regWrite(regWrite),
		.memWrite(memWrite), .memToReg(memToReg), .isBranch(isBranch),
		.isJump(isJump), .isOut(isOut), .isHalt(isHalt), .rs1(rs1), .rs2(rs2),
		.rd(rd), .immShort(immShort), .jumpTarget(jumpTarget)
	);

	regFile regs (
		.clk(clk), .rstN(rstN), .rs1(rs1), .rs2(rs2), .rd(rd),
		.wbEnable(wbEnable), .wbData(wbData),
		.rs1Data(rs1Data), .rs2Data(rs2Data), .rdData(rdData)
	);

	executeUnit execute (
		.aluOp(aluOp), .useImm(useImm), .isBranch(isBranch), .isJump(isJump),
		.rs1Data(rs1Data), .rs2Data(rs2Data), .rdData(rdData),
		.immShort(immShort), .jumpTarget(jumpTarget), .aluResult(aluResult),
		.redirect(redirect), .redirectPc(redirectPc)
	);

	resultUnit result (
		.clk(clk), .rstN(rstN), .aluResult(aluResult), .rdData(rdData),
		.regWrite(regWrite), .memWrite(memWrite), .memToReg(memToReg),
		.isOut(isOut), .wbData(wbData), .wbEnable(wbEnable),
		.outData(outData), .outStrobe(outStrobe)
	);

endmodule

/* verif/cpuTb.sv */
`timescale 1ns/1ps

module cpuTb
	import cpuPkg::*;
();

	localparam int resetCycles = 10;
	localparam int progLength = 45;  // Words in program.hex
	localparam int cycleLimit = 4 * progLength + resetCycles;
	localparam int quietCycles = 20;  // Watch window after the last OUT
	localparam int numOuts = 15;

	logic clk;
	logic rstN;
	logic [dataWidth-1:0] outData;
	logic outStrobe;
	logic halted;

	int errors = 0;
	int checks = 0;
	int cycleCount = 0;
	int idx;
	int quiet;

	// Expected OUT values in program order
	logic [dataWidth-1:0] expectedOut [0:numOuts-1] = '{
		32'h0000_0004, 32'h0000_000a, 32'hffff_fff1,  // ADD, SUB, SUBI into MUL
		32'h0000_0002, 32'h0000_000d, 32'h0000_000f,  // AND, XOR, OR
		32'h7fff_fffa, 32'h0000_0014,                 // NOT into SR, SL
		32'h0000_0001, 32'h0000_0000, 32'h0000_0001,  // SLT, SLET, SGT
		32'h0000_0001, 32'h0000_0000,                 // SGET, SET
		32'hffff_fff1,                                // LOAD back from address 5
		32'h0000_0007                                 // BNEQ not taken
	};

	cpuTop uut (
		.clk(clk),
		.rstN(rstN),
		.outData(outData),
		.outStrobe(outStrobe),
		.halted(halted)
	);

	always #50 clk = ~clk;

	// Summary line, then the verdict
	task automatic closeRun();
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	endtask

	// Outputs settle after the rising edge, so look at the falling edge
	task automatic waitForStrobe();
		do
			@(negedge clk);
		while (!outStrobe);
	endtask

	always @(posedge clk)
	begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= cycleLimit)
		begin
			$display("Timeout after %0d cycles, the program did not finish", cycleCount);
			errors = errors + 1;
			closeRun();
		end
	end

	initial
	begin
		clk = 1'b0;
		rstN = 1'b0;
		repeat (resetCycles) @(posedge clk);
		rstN <= 1'b1;

		for (idx = 0; idx < numOuts; idx++)
		begin
			waitForStrobe();
			checks++;
			if (outData !== expectedOut[idx])
			begin
				$display("Fail: outData entry %0d expected %h, got %h",
					idx, expectedOut[idx], outData);
				errors++;
			end
		end

		// HLT follows the last OUT, nothing more may come out
		for (quiet = 0; quiet < quietCycles; quiet++)
		begin
			@(negedge clk);
			if (outStrobe)
			begin
				$display("Unexpected output strobe after the last expected value");
				errors++;
			end
		end
		checks++;
		if (!halted)
		begin
			$display("Core did not halt after the last output");
			errors++;
		end
		closeRun();
	end

endmodule

/* program.hex */
// One instruction word per line: opcode[31:27] rd[26:22] rs1[21:17] rs2[16:12] or imm[16:0]
08400007 // ADDI r1, r0, 7
0881FFFD // ADDI r2, r0, -3
00C22000 // ADD r3, r1, r2
C8C00000 // OUT r3
11022000 // SUB r4, r1, r2
C9000000 // OUT r4
19420002 // SUBI r5, r1, 2
218A2000 // MUL r6, r5, r2
C9800000 // OUT r6
D0000000 // NOP
31C24000 // AND r7, r1, r4
C9C00000 // OUT r7
3A024000 // XOR r8, r1, r4
CA000000 // OUT r8
42424000 // OR r9, r1, r4
CA400000 // OUT r9
4A880000 // NOT r10, r4
7AD40000 // SR r11, r10
CAC00000 // OUT r11
83080000 // SL r12, r4
CB000000 // OUT r12
D0000000 // NOP
53441000 // SLT r13, r2, r1
CB400000 // OUT r13
5B822000 // SLET r14, r1, r2
CB800000 // OUT r14
63C22000 // SGT r15, r1, r2
CBC00000 // OUT r15
6C042000 // SGET r16, r2, r2
CC000000 // OUT r16
74422000 // SET r17, r1, r2
CC400000 // OUT r17
B9800005 // STORE r6, [r0 + 5]
09800000 // ADDI r6, r0, 0
B1800005 // LOAD r6, [r0 + 5]
C9800000 // OUT r6
0C800BAD // ADDI r18, r0, 0xBAD marker
A0420027 // BEQ r1, r1, 39
CC800000 // OUT r18 skipped
90000029 // J 41
CC800000 // OUT r18 skipped
A842002B // BNEQ r1, r1, 43
C8400000 // OUT r1
D8000000 // HLT
CC800000 // OUT r18 never reached

/* tb.f */
logic/cpuPkg.sv
logic/fetchUnit.sv
logic/decodeUnit.sv
logic/regFile.sv
logic/executeUnit.sv
logic/resultUnit.sv
logic/cpuTop.sv
verif/cpuTb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the processor testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

logFile=sim.log

verilator --binary --timing -Wno-fatal -f tb.f --top-module cpuTb -o cpuSim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/cpuSim > "$logFile" 2>&1
simStatus=$?
cat "$logFile"
if [ $simStatus -ne 0 ]; then
	echo "Simulation exited with status $simStatus"
	exit 1
fi

if grep -qx "RESULT: PASS" "$logFile"; then
	exit 0
fi
echo "Simulation did not pass, see $logFile"
exit 1
